// File: cache_pkg.sv
// Sizes, types and address field helpers for the four-way
// write-back data cache

package cache_pkg;

	localparam int ADDR_WIDTH     = 32;
	localparam int WORD_WIDTH     = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;
	localparam int NUM_SETS       = 16;
	localparam int NUM_WAYS       = 4;
	localparam int INDEX_WIDTH    = 4;
	localparam int OFFSET_WIDTH   = 2; // Word offset inside a line
	localparam int BYTE_BITS      = 2;
	localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - BYTE_BITS;

	typedef logic [ADDR_WIDTH-1:0]   addr_t;
	typedef logic [WORD_WIDTH-1:0]   word_t;
	typedef logic [LINE_WIDTH-1:0]   line_t;
	typedef logic [TAG_WIDTH-1:0]    tag_t;
	typedef logic [INDEX_WIDTH-1:0]  index_t;
	typedef logic [OFFSET_WIDTH-1:0] offset_t;
	typedef logic [1:0]              way_t;
	typedef logic [1:0]              age_t; // 0 is most recently used

	// Address layout from the MSB is tag, index, word offset and byte
	function automatic tag_t addr_tag(addr_t addr);
		return addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	endfunction

	function automatic index_t addr_index(addr_t addr);
		return addr[BYTE_BITS+OFFSET_WIDTH +: INDEX_WIDTH];
	endfunction

	function automatic offset_t addr_offset(addr_t addr);
		return addr[BYTE_BITS +: OFFSET_WIDTH];
	endfunction

	// Base address of a line for write-back and fill requests
	function automatic addr_t line_addr(tag_t tag, index_t index);
		addr_t addr;
		addr = '0;
		addr[ADDR_WIDTH-1 -: TAG_WIDTH] = tag;
		addr[BYTE_BITS+OFFSET_WIDTH +: INDEX_WIDTH] = index;
		return addr;
	endfunction

endpackage

// File: tag_if.sv
// Lookup and update signals between the cache controller and the tag store

`timescale 1ns/1ps

interface tag_if import cache_pkg::*; ();

	// Lookup key
	index_t index;
	tag_t   tag;

	// One-cycle command strobes acting on touch_way
	way_t touch_way;
	logic touch;
	logic fill;
	logic set_dirty;
	logic clean;

	// Lookup results
	logic   hit;
	way_t   hit_way;
	way_t   victim_way;
	tag_t   victim_tag;
	logic   victim_dirty;

	modport ctrl (
		output index, tag, touch_way, touch, fill, set_dirty, clean,
		input  hit, hit_way, victim_way, victim_tag, victim_dirty
	);

	modport store (
		input  index, tag, touch_way, touch, fill, set_dirty, clean,
		output hit, hit_way, victim_way, victim_tag, victim_dirty
	);

endinterface

// File: line_if.sv
// Access signals between the cache controller and the line data store

`timescale 1ns/1ps

interface line_if import cache_pkg::*; ();

	index_t  index;
	way_t    way;
	offset_t offset;

	logic  fill;       // Whole-line replace
	line_t fill_data;
	logic  write;      // Single word replace
	word_t write_data;

	line_t line_data;  // Line at index and way

	modport ctrl (
		output index, way, offset, fill, fill_data, write, write_data,
		input  line_data
	);

	modport store (
		input  index, way, offset, fill, fill_data, write, write_data,
		output line_data
	);

endinterface

// File: tag_store.sv
// Tag, valid, dirty and age storage per set and way
// Hit lookup, LRU victim choice and age update

`timescale 1ns/1ps

module tag_store import cache_pkg::*; (
	input logic clk,
	input logic reset,
	tag_if.store tags
);

	tag_t tag_mem   [NUM_SETS][NUM_WAYS];
	logic valid_mem [NUM_SETS][NUM_WAYS];
	logic dirty_mem [NUM_SETS][NUM_WAYS];
	age_t age_mem   [NUM_SETS][NUM_WAYS];

	age_t touched_age;
	logic do_touch;

	assign touched_age = age_mem[tags.index][tags.touch_way];
	assign do_touch    = tags.touch | tags.fill; // A fill counts as a use

	// Hit search over the addressed set
	always_comb begin
		tags.hit     = 1'b0;
		tags.hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (valid_mem[tags.index][w] && tag_mem[tags.index][w] == tags.tag) begin
				tags.hit     = 1'b1;
				tags.hit_way = way_t'(w);
			end
		end
	end

	// Victim is the oldest way of the set
	always_comb begin
		age_t oldest;
		oldest          = '0;
		tags.victim_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (age_mem[tags.index][w] > oldest) begin
				oldest          = age_mem[tags.index][w];
				tags.victim_way = way_t'(w);
			end
		end
	end

	assign tags.victim_tag   = tag_mem[tags.index][tags.victim_way];
	assign tags.victim_dirty = dirty_mem[tags.index][tags.victim_way];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					valid_mem[s][w] <= 1'b0;
					dirty_mem[s][w] <= 1'b0;
					age_mem[s][w]   <= age_t'(w); // Distinct ages from the start
				end
			end
		end else begin
			if (do_touch) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					if (way_t'(w) == tags.touch_way) begin
						age_mem[tags.index][w] <= '0;
					end else if (age_mem[tags.index][w] < touched_age) begin
						age_mem[tags.index][w] <= age_mem[tags.index][w] + 1'b1;
					end
				end
			end
			if (tags.fill) begin
				valid_mem[tags.index][tags.touch_way] <= 1'b1;
				dirty_mem[tags.index][tags.touch_way] <= 1'b0; // Fresh from next level
			end
			if (tags.set_dirty) begin
				dirty_mem[tags.index][tags.touch_way] <= 1'b1;
			end
			if (tags.clean) begin
				dirty_mem[tags.index][tags.touch_way] <= 1'b0;
			end
		end
	end

	// Tag written on fill
	always_ff @(posedge clk) begin
		if (tags.fill) begin
			tag_mem[tags.index][tags.touch_way] <= tags.tag;
		end
	end

endmodule

// File: line_store.sv
// Line data array with whole-line fill and single word write

`timescale 1ns/1ps

module line_store import cache_pkg::*; (
	input logic clk,
	input logic reset,
	line_if.store lines
);

	line_t line_mem [NUM_SETS][NUM_WAYS];

	assign lines.line_data = line_mem[lines.index][lines.way];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					line_mem[s][w] <= '0;
				end
			end
		end else begin
			if (lines.fill) begin
				line_mem[lines.index][lines.way] <= lines.fill_data;
			end
			// Only the addressed word changes on a write hit
			if (lines.write) begin
				line_mem[lines.index][lines.way][lines.offset*WORD_WIDTH +: WORD_WIDTH]
					<= lines.write_data;
			end
		end
	end

endmodule

// File: cache_ctrl.sv
// Cache controller FSM with IDLE, COMPARE, WRITE_BACK and ALLOCATE states
// Drives the tag and line stores and the next-level read and write requests

`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  req_read,
	input  logic  req_write,
	input  addr_t req_addr,
	input  word_t req_wdata,
	output logic  done,
	output logic  hit,
	output logic  miss,
	output word_t rdata,
	output logic  mem_read,
	output logic  mem_write,
	output addr_t mem_addr,
	output line_t mem_wdata,
	input  logic  mem_ack,
	input  line_t mem_rdata,
	tag_if.ctrl   tags,
	line_if.ctrl  lines
);

	typedef enum logic [1:0] {
		IDLE,
		COMPARE,
		WRITE_BACK,
		ALLOCATE
	} state_t;

	state_t state, next_state;

	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;
	logic    in_compare;

	assign req_tag    = addr_tag(req_addr);
	assign req_index  = addr_index(req_addr);
	assign req_offset = addr_offset(req_addr);
	assign in_compare = (state == COMPARE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (req_read || req_write) next_state = COMPARE;
			end
			COMPARE: begin
				if (tags.hit) begin
					next_state = IDLE;
				end else if (tags.victim_dirty) begin
					next_state = WRITE_BACK; // Victim has to go out first
				end else begin
					next_state = ALLOCATE;
				end
			end
			WRITE_BACK: begin
				if (mem_ack) next_state = ALLOCATE;
			end
			ALLOCATE: begin
				if (mem_ack) next_state = COMPARE; // Lookup again and hit
			end
			default: next_state = IDLE;
		endcase
	end

	// Requester side
	assign done  = in_compare & tags.hit;
	assign hit   = in_compare & tags.hit;
	assign miss  = in_compare & ~tags.hit;
	assign rdata = lines.line_data[req_offset*WORD_WIDTH +: WORD_WIDTH];

	// Tag store uses the hit way in COMPARE and the victim way elsewhere
	assign tags.index     = req_index;
	assign tags.tag       = req_tag;
	assign tags.touch_way = in_compare ? tags.hit_way : tags.victim_way;
	assign tags.touch     = in_compare & tags.hit;
	assign tags.set_dirty = in_compare & tags.hit & req_write;
	assign tags.clean     = (state == WRITE_BACK) & mem_ack;
	assign tags.fill      = (state == ALLOCATE) & mem_ack;

	// Line store
	assign lines.index      = req_index;
	assign lines.way        = tags.touch_way;
	assign lines.offset     = req_offset;
	assign lines.write      = in_compare & tags.hit & req_write;
	assign lines.write_data = req_wdata;
	assign lines.fill       = (state == ALLOCATE) & mem_ack;
	assign lines.fill_data  = mem_rdata;

	// Next-level requests stay up while the FSM waits for mem_ack
	assign mem_write = (state == WRITE_BACK);
	assign mem_read  = (state == ALLOCATE);
	assign mem_addr  = (state == WRITE_BACK) ? line_addr(tags.victim_tag, req_index)
	                                         : line_addr(req_tag, req_index);
	assign mem_wdata = lines.line_data;

endmodule

// File: l2_cache.sv
// Cache top level joining the controller, tag store and line store
// through the tag and line interfaces

`timescale 1ns/1ps

module l2_cache import cache_pkg::*; (
	input  logic  clk,
	input  logic  reset,

	// Requester
	input  logic  req_read,
	input  logic  req_write,
	input  addr_t req_addr,
	input  word_t req_wdata,
	output logic  done,
	output word_t rdata,
	output logic  hit,
	output logic  miss,

	// Next level
	output logic  mem_read,
	output logic  mem_write,
	output addr_t mem_addr,
	output line_t mem_wdata,
	input  logic  mem_ack,
	input  line_t mem_rdata
);

	tag_if  tags_i ();
	line_if lines_i ();

	cache_ctrl ctrl_i (
		.clk       (clk),
		.reset     (reset),
		.req_read  (req_read),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.done      (done),
		.hit       (hit),
		.miss      (miss),
		.rdata     (rdata),
		.mem_read  (mem_read),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.tags      (tags_i.ctrl),
		.lines     (lines_i.ctrl)
	);

	tag_store tag_store_i (
		.clk   (clk),
		.reset (reset),
		.tags  (tags_i.store)
	);

	line_store line_store_i (
		.clk   (clk),
		.reset (reset),
		.lines (lines_i.store)
	);

endmodule

// File: l2_cache_chk.sv
// Handshake assertions bound to the cache top level

`timescale 1ns/1ps

module l2_cache_chk import cache_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  req_read,
	input logic  req_write,
	input logic  done,
	input logic  hit,
	input logic  miss,
	input logic  mem_read,
	input logic  mem_write,
	input addr_t mem_addr,
	input logic  mem_ack
);

	// Next level sees one direction at a time
	assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
		else $error("mem_read and mem_write are high together");

	assert property (@(posedge clk) disable iff (reset) done |-> (req_read || req_write))
		else $error("done without a pending request");

	assert property (@(posedge clk) disable iff (reset)
		(mem_read && !mem_ack) |=> (mem_read && $stable(mem_addr)))
		else $error("mem_read or mem_addr changed before mem_ack");

	assert property (@(posedge clk) disable iff (reset)
		(mem_write && !mem_ack) |=> (mem_write && $stable(mem_addr)))
		else $error("mem_write or mem_addr changed before mem_ack");

	assert property (@(posedge clk) disable iff (reset) !(hit && miss))
		else $error("hit and miss in the same cycle");

endmodule

bind l2_cache l2_cache_chk l2_cache_chk_i (.*);

// File: tb_l2_cache.sv
// Cache testbench with clock, reset, next-level memory model,
// reference model of tags and LRU ages, directed tests

`timescale 1ns/1ps

module tb_l2_cache import cache_pkg::*; ();

	logic  clk;
	logic  reset;
	logic  req_read;
	logic  req_write;
	addr_t req_addr;
	word_t req_wdata;
	logic  done;
	logic  hit;
	logic  miss;
	word_t rdata;
	logic  mem_read;
	logic  mem_write;
	addr_t mem_addr;
	line_t mem_wdata;
	logic  mem_ack;
	line_t mem_rdata;

	line_t mem_lines [addr_t]; // Next level, keyed by line address
	int    op_trace;           // One decimal digit per next-level access (1 read, 2 write)
	addr_t wr_addr;
	addr_t rd_addr;
	line_t wr_data;

	// Reference model
	tag_t  m_tag   [NUM_SETS][NUM_WAYS];
	logic  m_valid [NUM_SETS][NUM_WAYS];
	logic  m_dirty [NUM_SETS][NUM_WAYS];
	age_t  m_age   [NUM_SETS][NUM_WAYS];
	line_t m_data  [NUM_SETS][NUM_WAYS];
	addr_t victim_addr;

	logic  seen_hit;
	logic  seen_miss;
	logic  seen_read;
	logic  seen_write;
	int    latency;
	word_t got_rdata;

	l2_cache l2_cache_i (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// Next level answers after 1 to 4 cycles
	initial begin
		int delay;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge clk);
			if (!reset && (mem_read || mem_write)) begin
				delay = $urandom_range(4, 1);
				repeat (delay - 1) @(negedge clk);
				@(posedge clk);
				#1;
				if (mem_write) begin
					mem_lines[mem_addr] = mem_wdata;
					wr_addr  = mem_addr;
					wr_data  = mem_wdata;
					op_trace = op_trace * 10 + 2;
				end else begin
					if (!mem_lines.exists(mem_addr)) begin
						mem_lines[mem_addr] = {$urandom, $urandom, $urandom, $urandom};
					end
					mem_rdata = mem_lines[mem_addr];
					rd_addr   = mem_addr;
					op_trace  = op_trace * 10 + 1;
				end
				mem_ack = 1'b1;
				@(posedge clk);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check(string name, logic [LINE_WIDTH-1:0] expected,
			logic [LINE_WIDTH-1:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	function automatic addr_t make_addr(tag_t tg, index_t idx, offset_t off);
		return {tg, idx, off, 2'b00};
	endfunction

	// Holds one request from just after a rising edge until done
	task automatic run_request(logic write, addr_t addr, word_t wdata, string name);
		int cycles;
		seen_hit   = 1'b0;
		seen_miss  = 1'b0;
		seen_read  = 1'b0;
		seen_write = 1'b0;
		op_trace   = 0;
		latency    = 0;
		cycles     = 0;
		req_read   = !write;
		req_write  = write;
		req_addr   = addr;
		req_wdata  = wdata;
		while (latency == 0) begin
			@(negedge clk);
			cycles++;
			seen_hit   |= hit;
			seen_miss  |= miss;
			seen_read  |= mem_read;
			seen_write |= mem_write;
			if (done) begin
				latency   = cycles;
				got_rdata = rdata;
			end else if (cycles > 100) begin
				$display("Timeout in %s: the cache never raised done", name);
				stop_with_failure();
			end
		end
		@(posedge clk);
		#1;
		req_read  = 1'b0;
		req_write = 1'b0;
	endtask

	task automatic do_read(string name, addr_t addr);
		run_request(1'b0, addr, '0, name);
	endtask

	task automatic do_write(string name, addr_t addr, word_t wdata);
		run_request(1'b1, addr, wdata, name);
	endtask

	// Predicts the access from the cache rules, runs it, compares, updates the model
	task automatic access(string name, logic write, addr_t addr, word_t wdata);
		index_t  idx;
		tag_t    tg;
		offset_t off;
		int      way;
		int      exp_trace;
		logic    exp_hit;
		idx       = addr[7:4];
		tg        = addr[31:8];
		off       = addr[3:2];
		exp_hit   = 1'b0;
		exp_trace = 0;
		way       = 0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
				exp_hit = 1'b1;
				way     = w;
			end
		end
		if (!exp_hit) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (m_age[idx][w] > m_age[idx][way]) way = w; // Oldest way goes
			end
			victim_addr = {m_tag[idx][way], idx, 4'h0};
			exp_trace   = m_dirty[idx][way] ? 21 : 1;
		end
		if (write) do_write(name, addr, wdata);
		else do_read(name, addr);
		check({name, " hit"}, 1, seen_hit);
		check({name, " miss"}, !exp_hit, seen_miss);
		check({name, " mem_read"}, !exp_hit, seen_read);
		check({name, " mem_write"}, exp_trace == 21, seen_write);
		check({name, " next level order"}, exp_trace, op_trace);
		if (exp_trace == 21) begin
			check({name, " write-back address"}, victim_addr, wr_addr);
			check({name, " write-back line"}, m_data[idx][way], wr_data);
		end
		if (!exp_hit) begin
			check({name, " fill address"}, {addr[31:4], 4'h0}, rd_addr);
			m_tag[idx][way]   = tg;
			m_valid[idx][way] = 1'b1;
			m_dirty[idx][way] = 1'b0;
			m_data[idx][way]  = mem_lines[{addr[31:4], 4'h0}];
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_age[idx][w] < m_age[idx][way]) m_age[idx][w]++;
		end
		m_age[idx][way] = '0;
		if (write) begin
			m_data[idx][way][off*WORD_WIDTH +: WORD_WIDTH] = wdata;
			m_dirty[idx][way] = 1'b1;
		end else begin
			check({name, " read data"}, m_data[idx][way][off*WORD_WIDTH +: WORD_WIDTH],
				got_rdata);
		end
	endtask

	task automatic read_miss_after_reset();
		access("read miss", 1'b0, make_addr(24'h000123, 4'h3, 2'd1), '0);
		check("read miss traffic", 1, op_trace);
	endtask

	task automatic read_hit_same_line();
		access("read hit", 1'b0, make_addr(24'h000123, 4'h3, 2'd2), '0);
		check("read hit latency", 2, latency);
		check("read hit traffic", 0, op_trace);
	endtask

	task automatic write_hit_and_read_back();
		access("write hit", 1'b1, make_addr(24'h000123, 4'h3, 2'd0), 32'hcafe_0001);
		check("write hit traffic", 0, op_trace);
		access("read after write", 1'b0, make_addr(24'h000123, 4'h3, 2'd0), '0);
		check("read after write data", 32'hcafe_0001, got_rdata);
	endtask

	task automatic dirty_eviction();
		addr_t first;
		first = make_addr(24'h000a00, 4'h5, 2'd1);
		access("evict write", 1'b1, first, 32'h5eed_0001);
		for (int t = 1; t < 5; t++) begin
			access("evict fill", 1'b0, make_addr(tag_t'(24'h000a00 + t), 4'h5, 2'd0), '0);
		end
		check("evict write then read", 21, op_trace);
		check("evict written word", 32'h5eed_0001, wr_data[63:32]);
		access("evict re-read", 1'b0, first, '0);
		check("evict re-read data", 32'h5eed_0001, got_rdata);
	endtask

	task automatic lru_order();
		addr_t lost;
		for (int t = 0; t < 4; t++) begin
			access("lru fill", 1'b0, make_addr(tag_t'(24'h000b00 + t), 4'h9, 2'd0), '0);
		end
		access("lru touch", 1'b0, make_addr(24'h000b01, 4'h9, 2'd3), '0);
		access("lru fifth tag", 1'b0, make_addr(24'h000b04, 4'h9, 2'd0), '0);
		lost = victim_addr; // Line the model evicted
		access("lru touched line", 1'b0, make_addr(24'h000b01, 4'h9, 2'd1), '0);
		check("lru touched line traffic", 0, op_trace);
		access("lru victim re-read", 1'b0, lost, '0);
		check("lru victim re-read mem_read", 1, seen_read);
	endtask

	initial begin
		void'($urandom(23));
		reset     = 1'b1;
		req_read  = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		op_trace  = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				m_tag[s][w]   = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_age[s][w]   = age_t'(w); // Reset ages follow way numbers
				m_data[s][w]  = '0;
			end
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		read_miss_after_reset();
		read_hit_same_line();
		write_hit_and_read_back();
		dirty_eviction();
		lru_order();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: tb.f
cache_pkg.sv
tag_if.sv
line_if.sv
tag_store.sv
line_store.sv
cache_ctrl.sv
l2_cache.sv
l2_cache_chk.sv
tb_l2_cache.sv

// File: run.sh
#!/bin/bash
# Builds the cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_l2_cache -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TEST OK$"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
